// ==== flist.f ====
logic/noc_pkg.sv
logic/flit_fifo.sv
logic/route_compute.sv
logic/output_arbiter.sv
logic/router_crossbar.sv
logic/noc_router.sv
testbench/noc_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the router testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module noc_router_tb \
  -f flist.f --Mdir obj_dir -o noc_router_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/noc_router_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
echo "Pass message missing from sim.log"
exit 1

// ==== testbench/noc_router_tb.sv ====
`timescale 1ns/1ps

module noc_router_tb import noc_pkg::*; ();

  localparam logic [2:0] router_x      = 3'd1;
  localparam logic [2:0] router_y      = 3'd1;
  localparam int         fifo_depth    = 4;
  localparam int         rand_per_port = 12;
  localparam int         num_packets   = 16 + NUM_PORTS * rand_per_port;
  // Destination that leaves through each port in the order N, E, W, S, L
  localparam int         dir_x [NUM_PORTS] = '{1, 2, 0, 1, 1};
  localparam int         dir_y [NUM_PORTS] = '{2, 1, 1, 0, 1};

  logic                 clk = 1'b0;
  logic                 rst;
  link_t                link_in  [NUM_PORTS];
  logic [NUM_PORTS-1:0] dcts_out;
  link_t                link_out [NUM_PORTS];
  logic [NUM_PORTS-1:0] dcts_in;

  logic [31:0]          lfsr = 32'h8269e299;
  flit_t                tx_q  [NUM_PORTS][$];  // Flits each input model still has to send
  int                   gap_q [NUM_PORTS][$];
  flit_t                exp_q [NUM_PORTS*NUM_PORTS][$];  // Index is output * 5 + input
  int                   src_log [NUM_PORTS][$];  // Source input of each packet seen at an output
  int                   owner     [NUM_PORTS];
  int                   accepted  [NUM_PORTS];
  int                   delivered [NUM_PORTS];
  flit_t                held_flit [NUM_PORTS];
  logic [NUM_PORTS-1:0] waiting;
  logic [NUM_PORTS-1:0] block;
  logic                 rand_bp;
  int                   pkt_id;

  noc_router #(
    .router_x  (router_x),
    .router_y  (router_y),
    .fifo_depth(fifo_depth)
  ) noc_router_i (
    .clk     (clk),
    .rst     (rst),
    .link_in (link_in),
    .dcts_out(dcts_out),
    .link_out(link_out),
    .dcts_in (dcts_in)
  );

  always #10 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  function automatic int expected_port(flit_t f);
    if (f.hdr.dst_x > router_x) return PORT_E;  // X is resolved before Y
    if (f.hdr.dst_x < router_x) return PORT_W;
    if (f.hdr.dst_y > router_y) return PORT_N;
    if (f.hdr.dst_y < router_y) return PORT_S;
    return PORT_L;
  endfunction

  // Order in which an idle output serves inputs
  function automatic int idle_rank(int p);
    case (p)
      PORT_L:  return 0;
      PORT_N:  return 1;
      PORT_E:  return 2;
      PORT_W:  return 3;
      default: return 4;
    endcase
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int k = 0; k < NUM_PORTS * NUM_PORTS; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  function automatic logic router_idle();
    logic idle;
    idle = (dcts_out == '1);
    for (int p = 0; p < NUM_PORTS; p++) begin
      idle = idle && !link_out[p].rts;
    end
    return idle;
  endfunction

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Payloads carry source and packet number so every flit is unique
  task automatic add_packet(int src, int dx, int dy, int n_body, int gap);
    flit_t f;
    int    o;
    f               = '0;
    f.hdr.flit_type = FLIT_HEAD;
    f.hdr.dst_x     = 3'(dx);
    f.hdr.dst_y     = 3'(dy);
    f.hdr.payload   = {3'(src), 13'(pkt_id), 8'h00};
    o               = expected_port(f);
    for (int k = 0; k <= n_body + 1; k++) begin
      if (k > 0) begin
        f.body.flit_type = (k > n_body) ? FLIT_TAIL : FLIT_BODY;
        f.body.payload   = {3'(src), 13'(pkt_id), 14'(k)};
      end
      tx_q[src].push_back(f);
      exp_q[o*NUM_PORTS+src].push_back(f);
    end
    gap_q[src].push_back(gap);
    pkt_id++;
  endtask

  // Flits of one packet go back to back with idle cycles only between packets
  task automatic stream_port(int p);
    flit_t f;
    int    gap;
    while (tx_q[p].size() > 0) begin
      f = tx_q[p].pop_front();
      @(negedge clk);
      link_in[p].flit = f;
      link_in[p].rts  = 1'b1;
      while (!dcts_out[p]) begin
        @(negedge clk);
      end
      accepted[p]++;  // Crosses on the coming rising edge
      if (f.body.flit_type == FLIT_TAIL) begin
        gap = gap_q[p].pop_front();
        if (gap > 0) begin
          @(negedge clk);
          link_in[p].rts = 1'b0;
          repeat (gap - 1) @(negedge clk);
        end
      end
    end
    @(negedge clk);
    link_in[p].rts = 1'b0;
  endtask

  task automatic run_streams();
    fork
      stream_port(PORT_N);
      stream_port(PORT_E);
      stream_port(PORT_W);
      stream_port(PORT_S);
      stream_port(PORT_L);
    join
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending() > 0) begin
      @(posedge clk);
      cycles++;
      assert (cycles < 5000) else begin
        $display("Traffic did not drain, %0d flits are still expected", pending());
        abort_run();
      end
    end
    repeat (4) @(posedge clk);  // Arbiters fall back to idle
  endtask

  task automatic wait_dcts_out(int p, logic val);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      assert (cycles < 100) else begin
        $display("dcts_out[%0d] never went to %0b", p, val);
        abort_run();
      end
    end while (dcts_out[p] != val);
  endtask

  // A packet holds its output from head to tail, so a head picks the source queue
  task automatic check_transfer(int o, flit_t f);
    int    src;
    int    idx;
    flit_t exp;
    src = owner[o];
    if (src < 0) begin
      assert (f.body.flit_type == FLIT_HEAD) else begin
        $display("[FAIL] %0t link_out[%0d].flit.flit_type expected %0d got %0d",
                 $time, o, FLIT_HEAD, f.body.flit_type);
        abort_run();
      end
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (exp_q[o*NUM_PORTS+i].size() > 0) begin
          if (exp_q[o*NUM_PORTS+i][0] == f) begin
            src = i;
          end
        end
      end
      assert (src >= 0) else begin
        $display("Output %0d sent head flit %h that no input sent there", o, f);
        abort_run();
      end
      owner[o] = src;
      src_log[o].push_back(src);
    end
    idx = o * NUM_PORTS + src;
    assert (exp_q[idx].size() > 0) else begin
      $display("Output %0d sent flit %h after its packet had ended", o, f);
      abort_run();
    end
    exp = exp_q[idx].pop_front();
    assert (f == exp) else begin
      $display("[FAIL] %0t link_out[%0d].flit expected %h got %h", $time, o, exp, f);
      abort_run();
    end
    delivered[o]++;
    if (f.body.flit_type == FLIT_TAIL) begin
      owner[o] = -1;
    end
  endtask

  task automatic check_order(int o, int a, int b);
    int first;
    first = (idle_rank(a) < idle_rank(b)) ? a : b;
    assert (src_log[o].size() == 2) else begin
      $display("Output %0d carried %0d packets instead of 2", o, src_log[o].size());
      abort_run();
    end
    assert (src_log[o][0] == first) else begin
      $display("[FAIL] %0t first source at output %0d expected %0d got %0d",
               $time, o, first, src_log[o][0]);
      abort_run();
    end
  endtask

  // Downstream link models check each transfer on the falling edge before it happens
  always @(negedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (block[o]) begin
        dcts_in[o] = 1'b0;
      end else if (rand_bp) begin
        dcts_in[o] = lfsr_bit();
      end else begin
        dcts_in[o] = 1'b1;
      end
      if (waiting[o]) begin
        assert (link_out[o].rts) else begin
          $display("[FAIL] %0t link_out[%0d].rts expected 1 got 0", $time, o);
          abort_run();
        end
        assert (link_out[o].flit == held_flit[o]) else begin
          $display("[FAIL] %0t link_out[%0d].flit expected %h got %h",
                   $time, o, held_flit[o], link_out[o].flit);
          abort_run();
        end
      end
      if (link_out[o].rts && dcts_in[o]) begin
        check_transfer(o, link_out[o].flit);
      end
      waiting[o]   = link_out[o].rts && !dcts_in[o];
      held_flit[o] = link_out[o].flit;
    end
  end

  initial begin : watchdog
    #(num_packets * 200);
    $display("Watchdog expired after %0d ns", num_packets * 200);
    abort_run();
  end

  initial begin : main_seq
    int rx;
    int ry;
    int nb;
    int gp;
    int cycles;
    int base;
    rst     = 1'b1;
    dcts_in = '1;
    block   = '0;
    rand_bp = 1'b0;
    waiting = '0;
    pkt_id  = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      link_in[p]   = '0;
      owner[p]     = -1;
      accepted[p]  = 0;
      delivered[p] = 0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      assert (!link_out[p].rts) else begin
        $display("[FAIL] %0t link_out[%0d].rts expected 0 got 1", $time, p);
        abort_run();
      end
    end
    assert (dcts_out == '1) else begin
      $display("[FAIL] %0t dcts_out expected 11111 got %b", $time, dcts_out);
      abort_run();
    end
    @(posedge clk);

    // Every input toward a different output, then local toward all five
    for (int p = 0; p < NUM_PORTS; p++) begin
      add_packet(p, dir_x[(p + 1) % NUM_PORTS], dir_y[(p + 1) % NUM_PORTS], 2, 1);
    end
    run_streams();
    wait_drain();
    for (int d = 0; d < NUM_PORTS; d++) begin
      add_packet(PORT_L, dir_x[d], dir_y[d], d % 3, 0);
    end
    run_streams();
    wait_drain();

    // Two heads reach the same idle output in one cycle
    for (int o = 0; o < NUM_PORTS; o++) begin
      src_log[o].delete();
    end
    add_packet(PORT_N, 1, 1, 2, 1);
    add_packet(PORT_S, 1, 1, 2, 1);
    add_packet(PORT_L, 2, 2, 1, 1);
    add_packet(PORT_W, 2, 0, 1, 1);
    run_streams();
    wait_drain();
    check_order(PORT_L, PORT_N, PORT_S);
    check_order(PORT_E, PORT_L, PORT_W);

    // North output stalled while a flit waits on it
    @(posedge clk);
    block[PORT_N] = 1'b1;
    add_packet(PORT_L, dir_x[PORT_N], dir_y[PORT_N], 2, 1);
    fork
      stream_port(PORT_L);
      begin
        cycles = 0;
        do begin
          @(negedge clk);
          cycles++;
          assert (cycles < 50) else begin
            $display("Blocked north output never raised rts");
            abort_run();
          end
        end while (!link_out[PORT_N].rts);
        repeat (10) @(negedge clk);
        @(posedge clk);
        block[PORT_N] = 1'b0;
      end
    join
    wait_drain();

    // Input buffer fills behind a blocked east output
    @(posedge clk);
    block[PORT_E]    = 1'b1;
    accepted[PORT_W] = 0;
    base             = delivered[PORT_E];
    add_packet(PORT_W, 2, 1, 6, 1);
    fork
      stream_port(PORT_W);
      begin
        wait_dcts_out(PORT_W, 1'b0);
        assert (accepted[PORT_W] == fifo_depth + delivered[PORT_E] - base) else begin
          $display("[FAIL] %0t accepted flits at dcts_out[%0d] drop expected %0d got %0d",
                   $time, PORT_W, fifo_depth + delivered[PORT_E] - base, accepted[PORT_W]);
          abort_run();
        end
        repeat (8) @(negedge clk);
        assert (!dcts_out[PORT_W]) else begin
          $display("[FAIL] %0t dcts_out[%0d] expected 0 got 1", $time, PORT_W);
          abort_run();
        end
        @(posedge clk);
        block[PORT_E] = 1'b0;
        wait_dcts_out(PORT_W, 1'b1);
      end
    join
    wait_drain();

    // Random destinations in a 3x3 area, random lengths, gaps and back-pressure
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int n = 0; n < rand_per_port; n++) begin
        rx = rand_bits(4) % 3;
        ry = rand_bits(4) % 3;
        nb = rand_bits(2);
        gp = rand_bits(2);
        add_packet(p, rx, ry, nb, gp);
      end
    end
    rand_bp = 1'b1;
    run_streams();
    wait_drain();
    @(posedge clk);
    rand_bp = 1'b0;
    @(negedge clk);

    if (pending() == 0 && router_idle()) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Router still holds traffic after all expected flits left");
      abort_run();
    end
  end

endmodule

// ==== logic/noc_router.sv ====
`timescale 1ns/1ps

module noc_router import noc_pkg::*; #(
  parameter logic [2:0] router_x   = 3'd0,
  parameter logic [2:0] router_y   = 3'd0,
  parameter int         fifo_depth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  link_t                link_in  [NUM_PORTS],
  output logic [NUM_PORTS-1:0] dcts_out,
  output link_t                link_out [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] dcts_in
);

  flit_t                head      [NUM_PORTS];
  logic [NUM_PORTS-1:0] not_empty;
  logic [NUM_PORTS-1:0] pops;
  logic [NUM_PORTS-1:0] in_req    [NUM_PORTS];  // Per input, one bit per output
  logic [NUM_PORTS-1:0] arb_req   [NUM_PORTS];  // Per output, one bit per input
  logic [NUM_PORTS-1:0] grant     [NUM_PORTS];
  logic [NUM_PORTS-1:0] xbar_sel  [NUM_PORTS];
  flit_t                xbar_flit [NUM_PORTS];

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    flit_fifo #(
      .fifo_depth(fifo_depth)
    ) flit_fifo_i (
      .clk      (clk),
      .rst      (rst),
      .link_in  (link_in[i]),
      .dcts     (dcts_out[i]),
      .pop      (pops[i]),
      .head     (head[i]),
      .not_empty(not_empty[i])
    );

    route_compute #(
      .router_x(router_x),
      .router_y(router_y)
    ) route_compute_i (
      .clk      (clk),
      .rst      (rst),
      .head     (head[i]),
      .not_empty(not_empty[i]),
      .pop      (pops[i]),
      .req      (in_req[i])
    );
  end

  for (genvar j = 0; j < NUM_PORTS; j++) begin : g_out
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_req
      assign arb_req[j][i] = in_req[i][j];
    end

    output_arbiter output_arbiter_i (
      .clk     (clk),
      .rst     (rst),
      .req     (arb_req[j]),
      .dcts    (dcts_in[j]),
      .grant   (grant[j]),
      .xbar_sel(xbar_sel[j]),
      .rts     (link_out[j].rts)
    );

    assign link_out[j].flit = xbar_flit[j];
  end

  router_crossbar router_crossbar_i (
    .heads    (head),
    .sel      (xbar_sel),
    .grants   (grant),
    .flits_out(xbar_flit),
    .pops     (pops)
  );

endmodule

// ==== logic/router_crossbar.sv ====
`timescale 1ns/1ps

module router_crossbar import noc_pkg::*; (
  input  flit_t                heads     [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] sel       [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] grants    [NUM_PORTS],
  output flit_t                flits_out [NUM_PORTS],
  output logic [NUM_PORTS-1:0] pops
);

  logic [NUM_PORTS-1:0] sel_by_input [NUM_PORTS];  // Bit o set when output o selects this input

  // AND-OR mux that gives an idle output all zeros
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      flits_out[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        flits_out[o] = flits_out[o] | (heads[i] & {$bits(flit_t){sel[o][i]}});
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      pops[i] = 1'b0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        pops[i]            = pops[i] | grants[o][i];
        sel_by_input[i][o] = sel[o][i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      assert ($onehot0(sel_by_input[i]))
        else $error("input %0d selected by more than one output", i);
    end
  end

endmodule

// ==== logic/output_arbiter.sv ====
`timescale 1ns/1ps

module output_arbiter import noc_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] req,
  input  logic                 dcts,
  output logic [NUM_PORTS-1:0] grant,
  output logic [NUM_PORTS-1:0] xbar_sel,
  output logic                 rts
);

  // Bit 0 is idle and bit i+1 means input i owns this output
  localparam logic [NUM_PORTS:0] idle_state = 6'b000001;

  logic [NUM_PORTS:0] state;
  logic [NUM_PORTS:0] next_state;
  logic [NUM_PORTS:0] state_d;
  logic               rts_d;
  int                 start_idx;
  int                 cand;

  assign xbar_sel = state[NUM_PORTS:1];
  assign grant    = xbar_sel & {NUM_PORTS{rts & dcts}};

  // The search begins at the current owner, so it keeps the output while it requests
  always_comb begin
    start_idx = PORT_L;  // From idle local is checked first, then N, E, W, S
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (xbar_sel[i]) begin
        start_idx = i;
      end
    end
  end

  // Walk the ring backwards so the nearest requester wins
  always_comb begin
    next_state = idle_state;
    cand       = 0;
    for (int k = NUM_PORTS - 1; k >= 0; k--) begin
      cand = (start_idx + k) % NUM_PORTS;
      if (req[cand]) begin
        next_state = idle_state << (cand + 1);
      end
    end
  end

  always_comb begin
    if (rts) begin
      state_d = dcts ? next_state : state;  // Back-pressure freezes the owner
      rts_d   = !dcts;                      // One idle cycle after every transfer
    end else begin
      state_d = next_state;
      rts_d   = |(xbar_sel & req);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle_state;
      rts   <= 1'b0;
    end else begin
      state <= state_d;
      rts   <= rts_d;
    end
  end

  // Only an input that still requests this output may have its flit taken
  a_grant_onehot0: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~req) == '0)
  ) else $error("output_arbiter granted an input that was not requesting it");

endmodule

// ==== logic/route_compute.sv ====
`timescale 1ns/1ps

module route_compute import noc_pkg::*; #(
  parameter logic [2:0] router_x = 3'd0,
  parameter logic [2:0] router_y = 3'd0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  flit_t                head,
  input  logic                 not_empty,
  input  logic                 pop,
  output logic [NUM_PORTS-1:0] req
);

  logic [NUM_PORTS-1:0] route_dec;
  logic [NUM_PORTS-1:0] req_q;  // Output chosen by the head of the packet in flight
  logic                 held;
  logic                 is_head;
  logic                 tail_pop;

  assign is_head  = not_empty && (head.body.flit_type == FLIT_HEAD);
  assign tail_pop = pop && (head.body.flit_type == FLIT_TAIL);

  // XY order resolves x before y
  always_comb begin
    route_dec = '0;
    if (head.hdr.dst_x > router_x) begin
      route_dec[PORT_E] = 1'b1;
    end else if (head.hdr.dst_x < router_x) begin
      route_dec[PORT_W] = 1'b1;
    end else if (head.hdr.dst_y > router_y) begin
      route_dec[PORT_N] = 1'b1;
    end else if (head.hdr.dst_y < router_y) begin
      route_dec[PORT_S] = 1'b1;
    end else begin
      route_dec[PORT_L] = 1'b1;
    end
  end

  // Request only while a flit is waiting at the head
  always_comb begin
    if (held) begin
      req = req_q & {NUM_PORTS{not_empty}};
    end else if (is_head) begin
      req = route_dec;
    end else begin
      req = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= 1'b0;
    end else if (tail_pop) begin
      held <= 1'b0;  // Wormhole closes when the tail leaves
    end else if (!held && is_head) begin
      held <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!held && is_head) begin
      req_q <= route_dec;
    end
  end

  // A packet reaching the front has to open with its head flit
  a_req_onehot0: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(req) && (held || !not_empty || head.body.flit_type == FLIT_HEAD)
  ) else $error("route_compute saw a packet without a head flit or a bad request");

endmodule

// ==== logic/flit_fifo.sv ====
`timescale 1ns/1ps

module flit_fifo import noc_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  link_t link_in,
  output logic  dcts,
  input  logic  pop,
  output flit_t head,
  output logic  not_empty
);

  localparam int addr_w = $clog2(fifo_depth);

  flit_t             mem [fifo_depth];
  logic [addr_w:0]   wr_ptr;  // Extra top bit tells full from empty
  logic [addr_w:0]   rd_ptr;
  logic              full;
  logic              push;

  assign full      = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                     (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
  assign not_empty = (wr_ptr != rd_ptr);
  assign dcts      = !full;
  assign push      = link_in.rts && dcts;  // Handshake edge at the input link
  assign head      = mem[rd_ptr[addr_w-1:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[addr_w-1:0]] <= link_in.flit;
    end
  end

  // A grant from some output must only ever reach a buffer holding a flit
  a_pop_not_empty: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> not_empty
  ) else $error("flit_fifo popped while empty");

  // While the buffer is full the upstream sender has to hold its flit
  a_full_hold: assert property (
    @(posedge clk) disable iff (rst)
    link_in.rts && full |=> link_in.rts && $stable(link_in.flit)
  ) else $error("flit offered to a full flit_fifo was not held");

endmodule

// ==== logic/noc_pkg.sv ====
package noc_pkg;

  localparam int NUM_PORTS = 5;

  // Index of each port in every five-wide one-hot vector
  localparam int PORT_N = 0;
  localparam int PORT_E = 1;
  localparam int PORT_W = 2;
  localparam int PORT_S = 3;
  localparam int PORT_L = 4;

  // Type code 2'b00 is unused
  localparam logic [1:0] FLIT_HEAD = 2'b01;
  localparam logic [1:0] FLIT_BODY = 2'b10;
  localparam logic [1:0] FLIT_TAIL = 2'b11;

  // Head flit carries the XY destination of the packet
  typedef struct packed {
    logic [1:0]  flit_type;
    logic [2:0]  dst_x;
    logic [2:0]  dst_y;
    logic [23:0] payload;
  } head_view_t;

  // Body and tail flits use everything after the type as payload
  typedef struct packed {
    logic [1:0]  flit_type;
    logic [29:0] payload;
  } body_view_t;

  // The type field lines up in both views, so either view can read it
  typedef union packed {
    head_view_t hdr;
    body_view_t body;
  } flit_t;

  // Forward half of a link while dcts travels back on its own wire
  typedef struct packed {
    flit_t flit;
    logic  rts;
  } link_t;

endpackage
